//--- include/delay_line_params.svh
`ifndef DELAY_LINE_PARAMS_SVH
`define DELAY_LINE_PARAMS_SVH

// width of one sample word
`define SAMPLE_WIDTH 16

// tap delays, counted in accepted enables
`define LONG_DELAY  64  // block ram tap
`define MID_DELAY   12  // lut ram tap
`define SHORT_DELAY 3   // flip-flop tap

`endif

//--- logic/delay_line_pkg.sv
`include "delay_line_params.svh"

package delay_line_pkg;

    // one sample of the input stream
    typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

    // address bits needed for a ram of the given depth
    // a depth of one still gets a one bit address
    function automatic int addr_bits(input int depth);
        int bits;
        bits = (depth > 1) ? $clog2(depth) : 1;
        return bits;
    endfunction

endpackage

//--- logic/sdp_ram_if.sv
`timescale 1ns/1ps

interface sdp_ram_if #(
    parameter int data_w = 16,  // word width
    parameter int addr_w = 4    // address width
) ();

    // write port
    logic              wen;
    logic [addr_w-1:0] waddr;
    logic [data_w-1:0] wdata;

    // read port, rdata valid the clock after ren
    logic              ren;
    logic [addr_w-1:0] raddr;
    logic [data_w-1:0] rdata;

    // side that owns the addresses
    modport ctrl (
        output wen, waddr, wdata,
        output ren, raddr,
        input  rdata
    );

    // memory side
    modport mem (
        input  wen, waddr, wdata,
        input  ren, raddr,
        output rdata
    );

endinterface

//--- logic/dram_simple_dual_port.sv
`timescale 1ns/1ps

// distributed ram with one write and one read port
// read path is combinational from the array into an output register
module dram_simple_dual_port #(
    parameter int mem_width = 16,  // word width
    parameter int mem_depth = 16   // number of words
) (
    input  logic    clk,
    input  logic    resetn,
    sdp_ram_if.mem  ram
);

    logic [mem_width-1:0] mem_q [mem_depth];  // lut storage
    logic [mem_width-1:0] rd_word;             // asynchronous read
    logic [mem_width-1:0] rd_q;                // registered read data

    // memory contents start at zero
    initial
    begin
        for (int i = 0; i < mem_depth; i++)
        begin
            mem_q[i] = '0;
        end
    end

    // write port, no reset on the array
    always @(posedge clk)
    begin
        if (ram.wen)
        begin
            mem_q[ram.waddr] <= ram.wdata;
        end
    end

    assign rd_word = mem_q[ram.raddr];  // lut read, no clock

    // the array is sampled before the write of the same edge lands
    // so a same-address access returns the old word
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rd_q <= '0;
        end
        else if (ram.ren)
        begin
            rd_q <= rd_word;
        end
    end

    assign ram.rdata = rd_q;

endmodule

//--- logic/bram_simple_dual_port.sv
`timescale 1ns/1ps

// block ram with one write and one read port
// one clock of read latency, read register has no reset
module bram_simple_dual_port #(
    parameter int mem_width = 16,  // word width
    parameter int mem_depth = 64   // number of words
) (
    input  logic    clk,
    sdp_ram_if.mem  ram
);

    logic [mem_width-1:0] mem_q [mem_depth];  // block storage
    logic [mem_width-1:0] rd_q;                // read register inside the ram

    // memory contents start at zero, so does the read register
    initial
    begin
        for (int i = 0; i < mem_depth; i++)
        begin
            mem_q[i] = '0;
        end
        rd_q = '0;
    end

    // write port
    always @(posedge clk)
    begin
        if (ram.wen)
        begin
            mem_q[ram.waddr] <= ram.wdata;
        end
    end

    // read port, read-first against the write above
    always @(posedge clk)
    begin
        if (ram.ren)
        begin
            rd_q <= mem_q[ram.raddr];
        end
    end

    assign ram.rdata = rd_q;

endmodule

//--- logic/ram_based_shift_regs.sv
`timescale 1ns/1ps

// fixed length shift register, advances once per enable
// storage is either a flip-flop chain or a ram with two rotating pointers
module ram_based_shift_regs
    import delay_line_pkg::*;
#(
    parameter int    data_width = $bits(sample_t),  // must equal the sample width
    parameter int    delay_n    = 16,               // delay in enables
    parameter string shift_type = "ram",            // "ram" or "ff"
    parameter string ram_type   = "lutram"          // "lutram" or "bram"
) (
    input  logic    clk,
    input  logic    resetn,
    input  sample_t shift_in_i,
    input  logic    ce_i,
    output sample_t shift_out_o
);

    generate
        if (shift_type == "ram")
        begin : g_ram
            localparam int addr_w = addr_bits(delay_n);

            typedef logic [addr_w-1:0] addr_t;

            localparam addr_t last_addr = addr_t'(delay_n - 1);

            addr_t wr_ptr;  // slot written this enable
            addr_t rd_ptr;  // slot about to be overwritten next enable

            sdp_ram_if #(
                .data_w(data_width),
                .addr_w(addr_w)
            ) ram_if ();

            // write one slot behind the read, so each slot is read
            // delay_n-1 enables after it was written
            always_ff @(posedge clk or negedge resetn)
            begin
                if (!resetn)
                begin
                    wr_ptr <= last_addr;
                    rd_ptr <= '0;
                end
                else if (ce_i)
                begin
                    wr_ptr <= (wr_ptr == last_addr) ? '0 : addr_t'(wr_ptr + 1'b1);
                    rd_ptr <= (rd_ptr == last_addr) ? '0 : addr_t'(rd_ptr + 1'b1);
                end
            end

            assign ram_if.wen   = ce_i;
            assign ram_if.waddr = wr_ptr;
            assign ram_if.wdata = shift_in_i;
            assign ram_if.ren   = ce_i;  // output only moves on an enable
            assign ram_if.raddr = rd_ptr;

            if (ram_type == "bram")
            begin : g_bram
                bram_simple_dual_port #(
                    .mem_width(data_width),
                    .mem_depth(delay_n)
                ) ram_u (
                    .clk(clk),
                    .ram(ram_if)
                );
            end
            else
            begin : g_lutram
                dram_simple_dual_port #(
                    .mem_width(data_width),
                    .mem_depth(delay_n)
                ) ram_u (
                    .clk(clk),
                    .resetn(resetn),
                    .ram(ram_if)
                );
            end

            assign shift_out_o = ram_if.rdata;  // ram output register is the last stage
        end
        else
        begin : g_ff
            logic [data_width-1:0] stage_q [delay_n];  // stage 0 takes the input

            always_ff @(posedge clk or negedge resetn)
            begin
                if (!resetn)
                begin
                    for (int i = 0; i < delay_n; i++)
                    begin
                        stage_q[i] <= '0;
                    end
                end
                else if (ce_i)
                begin
                    stage_q[0] <= shift_in_i;
                    for (int i = 1; i < delay_n; i++)
                    begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign shift_out_o = stage_q[delay_n-1];
        end
    endgenerate

endmodule

//--- logic/sample_delay_top.sv
`timescale 1ns/1ps
`include "delay_line_params.svh"

// one sample stream, three delayed copies
// each tap uses a different storage technology
module sample_delay_top
    import delay_line_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  sample_t sample_i,
    input  logic    sample_ce_i,
    output sample_t tap_long_o,
    output sample_t tap_mid_o,
    output sample_t tap_short_o
);

    // long tap in block ram
    ram_based_shift_regs #(
        .data_width(`SAMPLE_WIDTH),
        .delay_n(`LONG_DELAY),
        .shift_type("ram"),
        .ram_type("bram")
    ) tap_long_u (
        .clk(clk),
        .resetn(resetn),
        .shift_in_i(sample_i),
        .ce_i(sample_ce_i),
        .shift_out_o(tap_long_o)
    );

    // medium tap in lut ram
    ram_based_shift_regs #(
        .data_width(`SAMPLE_WIDTH),
        .delay_n(`MID_DELAY),
        .shift_type("ram"),
        .ram_type("lutram")
    ) tap_mid_u (
        .clk(clk),
        .resetn(resetn),
        .shift_in_i(sample_i),
        .ce_i(sample_ce_i),
        .shift_out_o(tap_mid_o)
    );

    // short tap, too short to be worth a ram
    ram_based_shift_regs #(
        .data_width(`SAMPLE_WIDTH),
        .delay_n(`SHORT_DELAY),
        .shift_type("ff"),
        .ram_type("lutram")  // ignored for ff storage
    ) tap_short_u (
        .clk(clk),
        .resetn(resetn),
        .shift_in_i(sample_i),
        .ce_i(sample_ce_i),
        .shift_out_o(tap_short_o)
    );

endmodule

//--- bench/tb_delay_model.sv
`timescale 1ns/1ps
`include "delay_line_params.svh"

// reference model of the three taps
// keeps the accepted samples since the last reset and looks the taps up by delay
module tb_delay_model
    import delay_line_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  sample_t sample_i,
    input  logic    ce_i,
    output sample_t exp_long_o,
    output sample_t exp_mid_o,
    output sample_t exp_short_o
);

    sample_t history [$];  // oldest entry at index 0

    // entry pushed delay pushes ago, the newest push counts as one
    // zero while fewer than delay samples were accepted
    function automatic sample_t expected_tap(input int delay);
        int n;
        n = history.size();
        if (n < delay)
        begin
            return '0;
        end
        return history[n - delay];
    endfunction

    always @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            history.delete();
            exp_long_o  <= '0;
            exp_mid_o   <= '0;
            exp_short_o <= '0;
        end
        else if (ce_i)
        begin
            history.push_back(sample_i);
            // the long tap needs the deepest history
            if (history.size() > `LONG_DELAY)
            begin
                void'(history.pop_front());
            end
            exp_long_o  <= expected_tap(`LONG_DELAY);
            exp_mid_o   <= expected_tap(`MID_DELAY);
            exp_short_o <= expected_tap(`SHORT_DELAY);
        end
    end

endmodule

//--- bench/tb_sample_delay_top.sv
`timescale 1ns/1ps
`include "delay_line_params.svh"

module tb_sample_delay_top
    import delay_line_pkg::*;
();

    localparam int clk_period    = 100;
    localparam int drive_delay   = 10;  // inputs change this long after the edge
    localparam int reset_cycles  = 2;
    localparam int idle_cycles   = 20;
    localparam int full_cycles   = 200;
    localparam int random_cycles = 300;
    localparam int flush_cycles  = `LONG_DELAY + 16;  // more than the longest delay
    localparam int tail_cycles   = 5;
    localparam int total_cycles  = 2 * reset_cycles + idle_cycles + full_cycles
                                 + random_cycles + flush_cycles + idle_cycles / 2
                                 + full_cycles + tail_cycles;
    localparam int watchdog_ns   = (total_cycles + 200) * clk_period;

    logic    clk;
    logic    resetn;
    sample_t sample;
    logic    sample_ce;
    sample_t tap_long;
    sample_t tap_mid;
    sample_t tap_short;
    sample_t exp_long;
    sample_t exp_mid;
    sample_t exp_short;

    integer seed;
    int     error_count;
    int     check_count;

    sample_delay_top uut (
        .clk(clk),
        .resetn(resetn),
        .sample_i(sample),
        .sample_ce_i(sample_ce),
        .tap_long_o(tap_long),
        .tap_mid_o(tap_mid),
        .tap_short_o(tap_short)
    );

    tb_delay_model model_u (
        .clk(clk),
        .resetn(resetn),
        .sample_i(sample),
        .ce_i(sample_ce),
        .exp_long_o(exp_long),
        .exp_mid_o(exp_mid),
        .exp_short_o(exp_short)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic report_mismatch(input string tap_name, input sample_t exp, input sample_t act);
        error_count++;
        $display("[FAIL] %0t ns: %s expected %h got %h", $time, tap_name, exp, act);
    endtask

    // one clock with the given sample and enable
    task automatic drive_cycle(input sample_t value, input logic ce);
        @(posedge clk);
        #(drive_delay);
        sample    = value;
        sample_ce = ce;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #(drive_delay);
        resetn    = 1'b0;
        sample_ce = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        resetn = 1'b1;
    endtask

    task automatic run_idle(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            drive_cycle(sample_t'($random(seed)), 1'b0);  // samples move, enable stays low
        end
    endtask

    task automatic run_enabled(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            drive_cycle(sample_t'($random(seed)), 1'b1);
        end
    endtask

    task automatic run_random_enable(input int cycles);
        logic [31:0] rnd;
        for (int i = 0; i < cycles; i++)
        begin
            rnd = $random(seed);
            drive_cycle(sample_t'(rnd[31:16]), rnd[0]);  // about half the cycles enabled
        end
    endtask

    // memories keep their words through a reset
    // zeros in every slot make the ram taps read zero afterwards
    task automatic run_zero_flush(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            drive_cycle('0, 1'b1);
        end
    endtask

    // taps settle right after the edge, look just before the next one
    always @(posedge clk)
    begin
        #(clk_period - drive_delay);
        check_count++;
        if (tap_long !== exp_long)
        begin
            report_mismatch("tap_long", exp_long, tap_long);
        end
        if (tap_mid !== exp_mid)
        begin
            report_mismatch("tap_mid", exp_mid, tap_mid);
        end
        if (tap_short !== exp_short)
        begin
            report_mismatch("tap_short", exp_short, tap_short);
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the stimulus did not finish within %0d ns", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        seed        = 32'hd4101bae;
        error_count = 0;
        check_count = 0;
        resetn      = 1'b0;
        sample      = '0;
        sample_ce   = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        resetn = 1'b1;

        run_idle(idle_cycles);          // taps stay zero without enables
        run_enabled(full_cycles);       // long tap wraps three times
        run_random_enable(random_cycles);
        run_zero_flush(flush_cycles);

        apply_reset();                  // second reset mid run
        run_idle(idle_cycles / 2);
        run_enabled(full_cycles);

        repeat (tail_cycles) drive_cycle('0, 1'b0);
        @(posedge clk);
        #(clk_period - drive_delay / 2);  // let the last compare finish

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sample_delay_top.f
+incdir+include
logic/delay_line_pkg.sv
logic/sdp_ram_if.sv
logic/dram_simple_dual_port.sv
logic/bram_simple_dual_port.sv
logic/ram_based_shift_regs.sv
logic/sample_delay_top.sv
bench/tb_delay_model.sv
bench/tb_sample_delay_top.sv
